// ==== Makefile ====
# Verilator build and run of the preload engine testbench

VERILATOR ?= verilator
TOP       ?= preloadTb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal

SOURCES := $(wildcard common/*.sv common/*.svh logic/*.sv l2Store/*.sv tests/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/preloadIfs.sv ====
`timescale 1ns/1ps

// Masked line write from the packer into the L2 store
interface lineWrIf;
    import preloadPkg::*;

    logic     valid;
    logic     ready;
    tLineAddr lineAddr;
    tLineData data;
    tLineMask mask;

    // Fields held from valid until ready
    modport packer (
        output valid,
        output lineAddr,
        output data,
        output mask,
        input  ready
    );

    modport store (
        input  valid,
        input  lineAddr,
        input  data,
        input  mask,
        output ready
    );
endinterface

// Single word readback from the store
interface wordRdIf;
    import preloadPkg::*;

    logic     req;
    logic     ack;
    tWordAddr addr;
    tWord     data;

    // Req and addr held until the one-cycle ack
    modport requester (
        output req,
        output addr,
        input  ack,
        input  data
    );

    modport store (
        input  req,
        input  addr,
        output ack,
        output data
    );
endinterface

// ==== common/preloadPkg.sv ====
`include "preload_settings.svh"

package preloadPkg;

    // One instruction or data word
    typedef logic [`PRELOAD_WORD_W-1:0] tWord;

    // Word index into the whole store
    typedef logic [$clog2(`PRELOAD_STORE_WORDS)-1:0] tWordAddr;

    // Line index, upper bits of a word index
    typedef logic [$clog2(`PRELOAD_STORE_LINES)-1:0] tLineAddr;

    // Word position inside a line, lower bits of a word index
    typedef logic [$clog2(`PRELOAD_LINE_WORDS)-1:0] tWordSel;

    // Full cache line, word 0 in the low bits
    typedef logic [`PRELOAD_LINE_WORDS*`PRELOAD_WORD_W-1:0] tLineData;

    // One bit per word present in a line
    typedef logic [`PRELOAD_LINE_WORDS-1:0] tLineMask;

    // APB slave phases
    typedef enum logic [1:0] {
        Idle,
        Setup,
        Access,
        WaitRead
    } tApbState;

endpackage

// ==== common/preload_settings.svh ====
`ifndef PRELOAD_SETTINGS_SVH
`define PRELOAD_SETTINGS_SVH

// Width of one instruction or data word
`define PRELOAD_WORD_W 32

// Words per cache line, 16 words make a 64-byte line
`define PRELOAD_LINE_WORDS 16

// Lines held in the L2 store
`define PRELOAD_STORE_LINES 8

// Total word capacity of the store
`define PRELOAD_STORE_WORDS (`PRELOAD_LINE_WORDS * `PRELOAD_STORE_LINES)

// APB address bus width
`define PRELOAD_APB_ADDR_W 8

`endif

// ==== l2Store/l2LineStore.sv ====
`timescale 1ns/1ps
`include "preload_settings.svh"

module l2LineStore (
    input  logic   clk,
    input  logic   rstN,
    lineWrIf.store wr,
    wordRdIf.store rd,
    output logic   commit
);
    import preloadPkg::*;

    // Line array
    tLineData lines [`PRELOAD_STORE_LINES];

    // Words written at least once, unwritten words read as zero
    tLineMask filled [`PRELOAD_STORE_LINES];

    tLineAddr rdLine;
    tWordSel  rdSel;
    logic     rdGo;

    assign rdLine = rd.addr[$bits(tWordAddr)-1 -: $bits(tLineAddr)];
    assign rdSel  = rd.addr[$bits(tWordSel)-1:0];

    // Busy only while handing back a read
    assign wr.ready = !rd.ack;
    assign commit   = wr.valid && wr.ready;

    // Pending line write wins over a read
    assign rdGo = rd.req && !rd.ack && !wr.valid;

    always_ff @(posedge clk) begin
        if (commit) begin
            // Merge under mask, words outside it survive
            for (int w = 0; w < `PRELOAD_LINE_WORDS; w++) begin
                if (wr.mask[w]) begin
                    lines[wr.lineAddr][w*`PRELOAD_WORD_W +: `PRELOAD_WORD_W] <=
                        wr.data[w*`PRELOAD_WORD_W +: `PRELOAD_WORD_W];
                end
            end
        end
        if (rdGo) begin
            if (filled[rdLine][rdSel]) begin
                rd.data <= lines[rdLine][rdSel*`PRELOAD_WORD_W +: `PRELOAD_WORD_W];
            end else begin
                rd.data <= '0;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rd.ack <= 1'b0;
            for (int l = 0; l < `PRELOAD_STORE_LINES; l++) begin
                filled[l] <= '0;
            end
        end else begin
            // One-cycle ack with the data
            rd.ack <= rdGo;
            if (commit) begin
                filled[wr.lineAddr] <= filled[wr.lineAddr] | wr.mask;
            end
        end
    end

    // Packer never sends an empty line
    noEmptyCommit: assert property (@(posedge clk) disable iff (!rstN)
        commit |-> (wr.mask != '0));

endmodule

// ==== logic/linePacker.sv ====
`timescale 1ns/1ps
`include "preload_settings.svh"

module linePacker (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 wordValid,
    output logic                 wordReady,
    input  preloadPkg::tWordAddr wordAddr,
    input  preloadPkg::tWord     wordData,
    input  logic                 flushReq,
    lineWrIf.packer              wr
);
    import preloadPkg::*;

    // Line being assembled
    tLineData bufData;
    tLineMask bufMask;
    tLineAddr bufLine;
    logic     flushPend;

    tLineAddr wordLine;
    tWordSel  wordSel;
    tLineData mergedData;
    tLineMask mergedMask;
    logic     lineChange;
    logic     take;
    logic     flushNow;
    logic     emitBuf;
    logic     emitFull;

    assign wordLine = wordAddr[$bits(tWordAddr)-1 -: $bits(tLineAddr)];
    assign wordSel  = wordAddr[$bits(tWordSel)-1:0];

    // Incoming word belongs to another line than the buffer
    assign lineChange = (bufMask != '0) && (wordLine != bufLine);

    // Out slot must be free before anything lands
    assign wordReady = !wr.valid && !flushPend && !flushReq && !lineChange;
    assign take      = wordValid && wordReady;
    assign flushNow  = (flushReq || flushPend) && !wr.valid;

    // Old line goes out first on a line change or flush
    assign emitBuf  = (flushNow && (bufMask != '0)) || (wordValid && lineChange && !wr.valid);
    assign emitFull = take && (&mergedMask);

    // Word dropped into its slot
    always_comb begin
        mergedData = bufData;
        mergedData[wordSel*`PRELOAD_WORD_W +: `PRELOAD_WORD_W] = wordData;
        mergedMask = bufMask | (tLineMask'(1) << wordSel);
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bufMask   <= '0;
            flushPend <= 1'b0;
            wr.valid  <= 1'b0;
        end else begin
            if (wr.valid && wr.ready) begin
                wr.valid <= 1'b0;
            end
            if (emitBuf || emitFull) begin
                wr.valid <= 1'b1;
                bufMask  <= '0;
            end else if (take) begin
                bufMask <= mergedMask;
            end
            // Flush waits while a line is in flight
            if (flushNow) begin
                flushPend <= 1'b0;
            end else if (flushReq) begin
                flushPend <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emitBuf) begin
            wr.lineAddr <= bufLine;
            wr.data     <= bufData;
            wr.mask     <= bufMask;
        end else if (emitFull) begin
            wr.lineAddr <= wordLine;
            wr.data     <= mergedData;
            wr.mask     <= mergedMask;
        end
        if (take) begin
            bufData <= mergedData;
            bufLine <= wordLine;
        end
    end

    // Line held steady until the store takes it
    lineHeld: assert property (@(posedge clk) disable iff (!rstN)
        wr.valid && !wr.ready |=> wr.valid && $stable(wr.lineAddr)
            && $stable(wr.data) && $stable(wr.mask));

endmodule

// ==== logic/preloadApbSlave.sv ====
`timescale 1ns/1ps
`include "preload_settings.svh"

module preloadApbSlave (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [`PRELOAD_APB_ADDR_W-1:0] paddr,
    input  preloadPkg::tWord               pwdata,
    output preloadPkg::tWord               prdata,
    output logic                           pready,
    output logic                           pslverr,
    output logic                           wordValid,
    input  logic                           wordReady,
    output preloadPkg::tWordAddr           wordAddr,
    output preloadPkg::tWord               wordData,
    output logic                           flushReq,
    wordRdIf.requester                     rd,
    input  logic                           commit
);
    import preloadPkg::*;

    // Register map
    localparam logic [`PRELOAD_APB_ADDR_W-1:0] offAddr  = 'h00;
    localparam logic [`PRELOAD_APB_ADDR_W-1:0] offData  = 'h04;
    localparam logic [`PRELOAD_APB_ADDR_W-1:0] offFlush = 'h08;
    localparam logic [`PRELOAD_APB_ADDR_W-1:0] offLines = 'h0C;
    localparam logic [`PRELOAD_APB_ADDR_W-1:0] offRdata = 'h10;

    tApbState state;
    tApbState nextState;

    // Extra top bit lets the pointer run past the store
    logic [$bits(tWordAddr):0] wordPtr;
    tWord lineCount;

    logic inAccess;
    logic dataWr;
    logic rdataRd;
    logic ptrOutside;

    // Setup means the setup phase was seen, so this is the first access cycle
    assign inAccess   = (state == Setup) || (state == Access);
    assign ptrOutside = wordPtr >= `PRELOAD_STORE_WORDS;
    assign dataWr     = inAccess && pwrite && (paddr == offData);
    assign rdataRd    = (state == Setup) && !pwrite && (paddr == offRdata);

    // Word toward the packer
    assign wordValid = dataWr && !ptrOutside;
    assign wordAddr  = tWordAddr'(wordPtr);
    assign wordData  = pwdata;

    // Single cycle, FLUSH always completes at once
    assign flushReq = (state == Setup) && pwrite && (paddr == offFlush);

    // Refused write ends immediately with an error
    assign pslverr = dataWr && ptrOutside;

    always_comb begin
        pready = 1'b0;
        case (state)
            Setup, Access: begin
                if (pwrite && (paddr == offData)) begin
                    pready = ptrOutside || wordReady;
                end else if (!pwrite && (paddr == offRdata)) begin
                    pready = 1'b0;
                end else begin
                    pready = 1'b1;
                end
            end
            WaitRead: pready = rd.ack;
            default:  pready = 1'b0;
        endcase
    end

    always_comb begin
        nextState = state;
        case (state)
            Idle: begin
                if (psel && !penable) begin
                    nextState = Setup;
                end
            end
            Setup, Access: begin
                if (pready) begin
                    nextState = Idle;
                end else if (rdataRd) begin
                    nextState = WaitRead;
                end else begin
                    // Only a DATA write stalls here
                    nextState = Access;
                end
            end
            WaitRead: begin
                if (rd.ack) begin
                    nextState = Idle;
                end
            end
            default: nextState = Idle;
        endcase
    end

    // Read mux
    always_comb begin
        prdata = '0;
        if (state == WaitRead) begin
            prdata = rd.data;
        end else if (!pwrite && (paddr == offAddr)) begin
            prdata = tWord'(wordPtr);
        end else if (!pwrite && (paddr == offLines)) begin
            prdata = lineCount;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= Idle;
            wordPtr   <= '0;
            lineCount <= '0;
            rd.req    <= 1'b0;
        end else begin
            state <= nextState;
            if (commit) begin
                lineCount <= lineCount + 1'b1;
            end
            if (inAccess && pwrite && pready) begin
                if (paddr == offAddr) begin
                    wordPtr <= pwdata[$bits(wordPtr)-1:0];
                end else if (paddr == offData) begin
                    // Advances on refused writes too
                    wordPtr <= wordPtr + 1'b1;
                end
            end
            if (rdataRd) begin
                rd.req <= 1'b1;
            end else if (rd.ack) begin
                rd.req <= 1'b0;
            end
        end
    end

    // Readback address captured with req
    always_ff @(posedge clk) begin
        if (rdataRd) begin
            rd.addr <= tWordAddr'(wordPtr);
        end
    end

    // Master keeps the transfer steady while we stall
    apbHeld: assert property (@(posedge clk) disable iff (!rstN)
        (state != Idle) && !pready |=> psel && $stable(paddr) && $stable(pwrite));

endmodule

// ==== logic/preloadTop.sv ====
`timescale 1ns/1ps
`include "preload_settings.svh"

module preloadTop (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [`PRELOAD_APB_ADDR_W-1:0] paddr,
    input  preloadPkg::tWord               pwdata,
    output preloadPkg::tWord               prdata,
    output logic                           pready,
    output logic                           pslverr
);
    import preloadPkg::*;

    // Word stream from slave to packer
    logic     wordValid;
    logic     wordReady;
    tWordAddr wordAddr;
    tWord     wordData;
    logic     flushReq;

    // Line commit pulse for the LINES counter
    logic commit;

    lineWrIf lineWr ();
    wordRdIf wordRd ();

    preloadApbSlave iApbSlave (
        .clk       (clk),
        .rstN      (rstN),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .wordValid (wordValid),
        .wordReady (wordReady),
        .wordAddr  (wordAddr),
        .wordData  (wordData),
        .flushReq  (flushReq),
        .rd        (wordRd.requester),
        .commit    (commit)
    );

    linePacker iPacker (
        .clk       (clk),
        .rstN      (rstN),
        .wordValid (wordValid),
        .wordReady (wordReady),
        .wordAddr  (wordAddr),
        .wordData  (wordData),
        .flushReq  (flushReq),
        .wr        (lineWr.packer)
    );

    l2LineStore iStore (
        .clk    (clk),
        .rstN   (rstN),
        .wr     (lineWr.store),
        .rd     (wordRd.store),
        .commit (commit)
    );

endmodule

// ==== tb.f ====
+incdir+common
common/preloadPkg.sv
common/preloadIfs.sv
logic/preloadApbSlave.sv
logic/linePacker.sv
l2Store/l2LineStore.sv
logic/preloadTop.sv
tests/preloadTb.sv

// ==== tests/preloadTb.sv ====
`timescale 1ns/1ps
`include "preload_settings.svh"

module preloadTb;
    import preloadPkg::*;

    // Register offsets copied from the slave's map
    localparam logic [`PRELOAD_APB_ADDR_W-1:0] regAddr  = 'h00;
    localparam logic [`PRELOAD_APB_ADDR_W-1:0] regData  = 'h04;
    localparam logic [`PRELOAD_APB_ADDR_W-1:0] regFlush = 'h08;
    localparam logic [`PRELOAD_APB_ADDR_W-1:0] regLines = 'h0C;
    localparam logic [`PRELOAD_APB_ADDR_W-1:0] regRdata = 'h10;
    localparam int storeWords = `PRELOAD_STORE_WORDS;
    localparam int lineWords  = `PRELOAD_LINE_WORDS;

    // Sum of APB accesses over all tests rounded up
    localparam int accessBudget = 250;

    logic                           clk;
    logic                           rstN;
    logic                           psel;
    logic                           penable;
    logic                           pwrite;
    logic [`PRELOAD_APB_ADDR_W-1:0] paddr;
    tWord                           pwdata;
    tWord                           prdata;
    logic                           pready;
    logic                           pslverr;

    // Store image plus the line the packer still holds
    tWord        memModel [storeWords];
    tWord        pendWords [lineWords];
    tLineMask    pendMask;
    int          pendLine;
    int          modelPtr;
    int          modelLines;
    logic [31:0] lfsr;

    // Expectation for the transfer in flight
    tWord  expValue;
    logic  expErr;
    string testName;
    int    errorCount;
    int    errAtStart;
    int    testsRun;
    int    testsFailed;

    preloadTop i_dut (
        .clk     (clk),
        .rstN    (rstN),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic tWord randWord(int nBits);
        tWord r;
        r = '0;
        for (int i = 0; i < nBits; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsrStep(lfsr);
        end
        return r;
    endfunction

    // Held line lands in the store image under its mask
    function automatic void commitPending();
        for (int w = 0; w < lineWords; w++) begin
            if (pendMask[w]) begin
                memModel[pendLine * lineWords + w] = pendWords[w];
            end
        end
        if (pendMask != '0) begin
            modelLines++;
        end
        pendMask = '0;
    endfunction

    // Line change pushes the old line out first and a full mask pushes this one
    function automatic void modelWord(int addr, tWord d);
        if (addr >= storeWords) begin
            return;
        end
        if ((pendMask != '0) && (addr / lineWords != pendLine)) begin
            commitPending();
        end
        pendLine = addr / lineWords;
        pendWords[addr % lineWords] = d;
        pendMask[addr % lineWords] = 1'b1;
        if (&pendMask) begin
            commitPending();
        end
    endfunction

    // Pending words are not visible yet
    function automatic tWord expRdata(int addr);
        return memModel[addr];
    endfunction

    function automatic tWord expLines();
        return tWord'(modelLines);
    endfunction

    task automatic apbTransfer(logic wr, logic [`PRELOAD_APB_ADDR_W-1:0] addr, tWord data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        // Combinational pready sampled mid-cycle
        @(negedge clk);
        while (!pready) @(negedge clk);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apbWrite(logic [`PRELOAD_APB_ADDR_W-1:0] addr, tWord data);
        expErr = (addr == regData) && (modelPtr >= storeWords);
        apbTransfer(1'b1, addr, data);
        if (addr == regAddr) begin
            modelPtr = int'(data[7:0]);
        end else if (addr == regData) begin
            modelWord(modelPtr, data);
            modelPtr++;
        end else if (addr == regFlush) begin
            commitPending();
        end
    endtask

    task automatic apbRead(logic [`PRELOAD_APB_ADDR_W-1:0] addr, tWord expected);
        expValue = expected;
        apbTransfer(1'b0, addr, '0);
    endtask

    // Point at a word and read it back
    task automatic checkWord(int addr);
        apbWrite(regAddr, addr);
        apbRead(regRdata, expRdata(addr));
    endtask

    task automatic startTest(string name);
        testName   = name;
        errAtStart = errorCount;
    endtask

    task automatic endTest();
        testsRun++;
        if (errorCount != errAtStart) begin
            testsFailed++;
            $display("%s: failed with %0d errors", testName, errorCount - errAtStart);
        end else begin
            $display("%s: ok", testName);
        end
    endtask

    // Every completed transfer checked against the model
    always @(negedge clk) begin
        if (psel && penable && pready) begin
            if (pwrite && (pslverr !== expErr)) begin
                $display("Error %s: expected pslverr %b actual %b", testName, expErr, pslverr);
                errorCount++;
            end
            if (!pwrite && (prdata !== expValue)) begin
                $display("Error %s: expected %h actual %h", testName, expValue, prdata);
                errorCount++;
            end
        end
    end

    initial begin
        repeat (accessBudget * 40) @(posedge clk);
        $display("Watchdog: tests did not finish within %0d cycles", accessBudget * 40);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int base;
        rstN       = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        lfsr       = 32'h3604_d3dd;
        pendMask   = '0;
        pendLine   = 0;
        modelPtr   = 0;
        modelLines = 0;
        expValue   = '0;
        expErr     = 1'b0;
        errorCount = 0;
        testsRun   = 0;
        testsFailed = 0;
        for (int a = 0; a < storeWords; a++) begin
            memModel[a] = '0;
        end
        repeat (8) @(posedge clk);
        rstN <= 1'b1;

        startTest("reset");
        apbRead(regLines, expLines());
        apbRead(regAddr, tWord'(modelPtr));
        apbRead(regRdata, expRdata(0));
        endTest();

        // Line 0 fills up and goes out on its own
        startTest("fullLine");
        apbWrite(regAddr, 0);
        for (int i = 0; i < lineWords; i++) begin
            apbWrite(regData, randWord(32));
        end
        apbRead(regLines, expLines());
        for (int a = 0; a < lineWords; a++) begin
            checkWord(a);
        end
        endTest();

        startTest("flushPending");
        apbWrite(regAddr, 32);
        repeat (5) apbWrite(regData, randWord(32));
        checkWord(34);
        apbWrite(regFlush, 0);
        checkWord(34);
        apbRead(regLines, expLines());
        endTest();

        // Word 4 of line 4 rewritten alone
        // Line 1 in between leaves other data in packer slots 3 to 5
        startTest("maskedMerge");
        apbWrite(regAddr, 67);
        repeat (3) apbWrite(regData, randWord(32));
        apbWrite(regFlush, 0);
        apbWrite(regAddr, 19);
        repeat (3) apbWrite(regData, randWord(32));
        apbWrite(regFlush, 0);
        apbWrite(regAddr, 68);
        apbWrite(regData, randWord(32));
        apbWrite(regFlush, 0);
        for (int a = 64; a < 72; a++) begin
            checkWord(a);
        end
        endTest();

        // Third write lands past the store
        startTest("storeLimit");
        apbWrite(regAddr, 126);
        repeat (3) apbWrite(regData, randWord(32));
        apbRead(regAddr, tWord'(modelPtr));
        apbWrite(regFlush, 0);
        checkWord(126);
        checkWord(127);
        endTest();

        // Words 58 to 97 span lines 3 to 6
        startTest("stream");
        apbWrite(regAddr, 58);
        for (int i = 0; i < 40; i++) begin
            apbWrite(regData, randWord(32));
            if (i % 8 == 7) begin
                base = modelPtr;
                checkWord(int'(randWord(7)));
                apbWrite(regAddr, base);
            end
        end
        apbRead(regLines, expLines());
        apbWrite(regFlush, 0);
        apbRead(regLines, expLines());
        for (int a = 58; a < 98; a++) begin
            checkWord(a);
        end
        endTest();

        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errorCount);
        if ((errorCount == 0) && (testsFailed == 0)) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
